//--- source/soc_io_defs.svh
// Address map, register offsets and bus widths of the I/O path
`ifndef SOC_IO_DEFS_SVH
`define SOC_IO_DEFS_SVH

// Bus widths
`define IO_ADDR_W       16
`define IO_DATA_W       32
`define IO_STRB_W       4

// Regions, 256 bytes each, picked by address bits 15:8
`define GPIO_BASE       16'h0000
`define SYSCON_BASE     16'h0100

// GPIO register offsets
`define GPIO_DATA_IN    8'h00
`define GPIO_DATA_OUT   8'h04
`define GPIO_DIR        8'h08
`define GPIO_IRQ_MASK   8'h0C
`define GPIO_IRQ_STAT   8'h10

// System controller register offsets
`define SYSCON_ID       8'h00
`define SYSCON_SW_IRQ   8'h04
`define SYSCON_STATUS   8'h08
`define SYSCON_ID_VALUE 32'h5357_0001

// AXI response codes
`define RESP_OKAY       2'b00
`define RESP_SLVERR     2'b10

`endif

//--- source/soc_io_pkg.sv
// Enums and packed structs shared by bridge, decoder and peripherals
`include "soc_io_defs.svh"

package soc_io_pkg;

   // Bridge FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_RESP
   } bridge_state_e;

   // Access kind on the internal bus
   typedef enum logic {
      OP_READ,
      OP_WRITE
   } io_op_e;

   //**************************************************************************
   // Internal single-beat bus
   //**************************************************************************

   // stb held until ack or err
   typedef struct packed {
      logic                  stb;
      io_op_e                op;
      logic [`IO_ADDR_W-1:0] addr;
      logic [`IO_DATA_W-1:0] wdata;
      logic [`IO_STRB_W-1:0] strb;
   } io_req_t;

   // ack and err are one-cycle pulses, never together
   typedef struct packed {
      logic                  ack;
      logic                  err;
      logic [`IO_DATA_W-1:0] rdata;
   } io_rsp_t;

   // GPIO pad drive
   typedef struct packed {
      logic [`IO_DATA_W-1:0] out;
      logic [`IO_DATA_W-1:0] oe;
   } gpio_pad_t;

endpackage

//--- source/axil_wb_bridge.sv
// AXI4-Lite slave front end
// Captures AW, W and AR beats and runs one bus request at a time
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module axil_wb_bridge (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic [`IO_ADDR_W-1:0] i_awaddr,
   input  logic                  i_awvalid,
   output logic                  o_awready,
   input  logic [`IO_DATA_W-1:0] i_wdata,
   input  logic [`IO_STRB_W-1:0] i_wstrb,
   input  logic                  i_wvalid,
   output logic                  o_wready,
   output logic [1:0]            o_bresp,
   output logic                  o_bvalid,
   input  logic                  i_bready,
   input  logic [`IO_ADDR_W-1:0] i_araddr,
   input  logic                  i_arvalid,
   output logic                  o_arready,
   output logic [`IO_DATA_W-1:0] o_rdata,
   output logic [1:0]            o_rresp,
   output logic                  o_rvalid,
   input  logic                  i_rready,
   output soc_io_pkg::io_req_t   o_req,
   input  soc_io_pkg::io_rsp_t   i_rsp
);
   import soc_io_pkg::*;

   bridge_state_e         state;
   io_op_e                op_q;
   logic                  aw_got;
   logic                  w_got;
   logic [`IO_ADDR_W-1:0] addr_q;
   logic [`IO_DATA_W-1:0] wdata_q;
   logic [`IO_STRB_W-1:0] strb_q;
   logic [`IO_DATA_W-1:0] rdata_q;
   logic [1:0]            resp_q;
   logic                  aw_hs;
   logic                  w_hs;
   logic                  ar_hs;
   logic                  wr_go;
   logic                  rsp_hit;
   logic                  resp_done;

   //**************************************************************************
   // Channel handshakes
   //**************************************************************************

   assign o_awready = (state == ST_IDLE) && !aw_got;
   assign o_wready  = (state == ST_IDLE) && !w_got;
   // Pending write beats win over a read
   assign o_arready = (state == ST_IDLE) && !aw_got && !w_got && !i_awvalid && !i_wvalid;

   assign aw_hs = i_awvalid && o_awready;
   assign w_hs  = i_wvalid && o_wready;
   assign ar_hs = i_arvalid && o_arready;
   assign wr_go = (aw_got || aw_hs) && (w_got || w_hs);

   assign rsp_hit   = ((state == ST_ISSUE) || (state == ST_WAIT)) && (i_rsp.ack || i_rsp.err);
   assign resp_done = (o_bvalid && i_bready) || (o_rvalid && i_rready);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state  <= ST_IDLE;
         op_q   <= OP_READ;
         aw_got <= 1'b0;
         w_got  <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (wr_go) begin
                  state  <= ST_ISSUE;
                  op_q   <= OP_WRITE;
                  aw_got <= 1'b0;
                  w_got  <= 1'b0;
               end else begin
                  if (aw_hs)
                     aw_got <= 1'b1;
                  if (w_hs)
                     w_got <= 1'b1;
                  if (ar_hs) begin
                     state <= ST_ISSUE;
                     op_q  <= OP_READ;
                  end
               end
            end
            ST_ISSUE, ST_WAIT: begin
               state <= rsp_hit ? ST_RESP : ST_WAIT;
            end
            ST_RESP: begin
               if (resp_done)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Captured beats and the returned response
   always_ff @(posedge i_clk) begin
      if (aw_hs)
         addr_q <= i_awaddr;
      else if (ar_hs)
         addr_q <= i_araddr;
      if (w_hs) begin
         wdata_q <= i_wdata;
         strb_q  <= i_wstrb;
      end
      if (rsp_hit) begin
         resp_q  <= i_rsp.err ? `RESP_SLVERR : `RESP_OKAY;
         rdata_q <= i_rsp.err ? '0 : i_rsp.rdata;
      end
   end

   assign o_req = '{stb: (state == ST_ISSUE) || (state == ST_WAIT),
                    op: op_q, addr: addr_q, wdata: wdata_q, strb: strb_q};

   assign o_bvalid = (state == ST_RESP) && (op_q == OP_WRITE);
   assign o_rvalid = (state == ST_RESP) && (op_q == OP_READ);
   assign o_bresp  = resp_q;
   assign o_rresp  = resp_q;
   assign o_rdata  = rdata_q;

endmodule

//--- source/io_addr_decode.sv
// Region decoder between the bridge and the peripherals
// Unmapped regions get a registered err
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module io_addr_decode (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::io_req_t i_req,
   output soc_io_pkg::io_rsp_t o_rsp,
   output soc_io_pkg::io_req_t o_gpio_req,
   input  soc_io_pkg::io_rsp_t i_gpio_rsp,
   output soc_io_pkg::io_req_t o_sys_req,
   input  soc_io_pkg::io_rsp_t i_sys_rsp
);

   localparam logic [7:0] GPIO_REGION = 8'(`GPIO_BASE >> 8);
   localparam logic [7:0] SYS_REGION  = 8'(`SYSCON_BASE >> 8);

   logic gpio_sel;
   logic sys_sel;
   logic err_q;

   assign gpio_sel = (i_req.addr[15:8] == GPIO_REGION);
   assign sys_sel  = (i_req.addr[15:8] == SYS_REGION);

   // Same request to both, stb only where selected
   always_comb begin
      o_gpio_req     = i_req;
      o_gpio_req.stb = i_req.stb && gpio_sel;
      o_sys_req      = i_req;
      o_sys_req.stb  = i_req.stb && sys_sel;
   end

   // One err pulse per unmapped request
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         err_q <= 1'b0;
      else
         err_q <= i_req.stb && !gpio_sel && !sys_sel && !err_q;
   end

   always_comb begin
      o_rsp.ack = i_gpio_rsp.ack || i_sys_rsp.ack;
      o_rsp.err = i_gpio_rsp.err || i_sys_rsp.err || err_q;
      if (gpio_sel)
         o_rsp.rdata = i_gpio_rsp.rdata;
      else if (sys_sel)
         o_rsp.rdata = i_sys_rsp.rdata;
      else
         o_rsp.rdata = '0;
   end

endmodule

//--- source/gpio_regs.sv
// 32-bit GPIO with output, direction, input sync and change interrupt
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module gpio_regs (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  soc_io_pkg::io_req_t   i_req,
   output soc_io_pkg::io_rsp_t   o_rsp,
   input  logic [`IO_DATA_W-1:0] i_gpio,
   output soc_io_pkg::gpio_pad_t o_pad,
   output logic                  o_irq
);
   import soc_io_pkg::*;

   logic [`IO_DATA_W-1:0] data_out;
   logic [`IO_DATA_W-1:0] dir;
   logic [`IO_DATA_W-1:0] irq_mask;
   logic [`IO_DATA_W-1:0] irq_stat;
   logic [`IO_DATA_W-1:0] sync_1;
   logic [`IO_DATA_W-1:0] sync_2;
   logic [`IO_DATA_W-1:0] sync_prev;
   logic [`IO_DATA_W-1:0] strb_mask;
   logic [`IO_DATA_W-1:0] wr_bits;
   logic [`IO_DATA_W-1:0] stat_clr;
   logic [`IO_DATA_W-1:0] rd_data;
   logic [`IO_DATA_W-1:0] rdata_q;
   logic                  hit;
   logic                  req_new;
   logic                  wr_en;
   logic                  ack_q;
   logic                  err_q;

   //**************************************************************************
   // Register access
   //**************************************************************************

   always_comb begin
      for (int b = 0; b < `IO_STRB_W; b++)
         strb_mask[b*8 +: 8] = {8{i_req.strb[b]}};
   end

   always_comb begin
      hit     = 1'b1;
      rd_data = '0;
      case (i_req.addr[7:0])
         `GPIO_DATA_IN:  rd_data = sync_2;
         `GPIO_DATA_OUT: rd_data = data_out;
         `GPIO_DIR:      rd_data = dir;
         `GPIO_IRQ_MASK: rd_data = irq_mask;
         `GPIO_IRQ_STAT: rd_data = irq_stat;
         default:        hit = 1'b0;
      endcase
   end

   assign req_new  = i_req.stb && !ack_q && !err_q;
   assign wr_en    = req_new && hit && (i_req.op == OP_WRITE);
   assign wr_bits  = i_req.wdata & strb_mask;
   assign stat_clr = (wr_en && (i_req.addr[7:0] == `GPIO_IRQ_STAT)) ? wr_bits : '0;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         data_out  <= '0;
         dir       <= '0;
         irq_mask  <= '0;
         irq_stat  <= '0;
         sync_1    <= '0;
         sync_2    <= '0;
         sync_prev <= '0;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         sync_1    <= i_gpio;
         sync_2    <= sync_1;
         sync_prev <= sync_2;
         // New edges win over a clear in the same cycle
         irq_stat  <= (irq_stat & ~stat_clr) | (sync_2 ^ sync_prev);
         if (wr_en && (i_req.addr[7:0] == `GPIO_DATA_OUT))
            data_out <= (data_out & ~strb_mask) | wr_bits;
         if (wr_en && (i_req.addr[7:0] == `GPIO_DIR))
            dir <= (dir & ~strb_mask) | wr_bits;
         if (wr_en && (i_req.addr[7:0] == `GPIO_IRQ_MASK))
            irq_mask <= (irq_mask & ~strb_mask) | wr_bits;
         ack_q <= req_new && hit;
         err_q <= req_new && !hit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (req_new)
         rdata_q <= (hit && (i_req.op == OP_READ)) ? rd_data : '0;
   end

   assign o_rsp = '{ack: ack_q, err: err_q, rdata: rdata_q};
   assign o_pad = '{out: data_out, oe: dir};
   assign o_irq = |(irq_stat & irq_mask);

endmodule

//--- source/syscon_regs.sv
// System controller with ID, software interrupts and status
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module syscon_regs (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  soc_io_pkg::io_req_t i_req,
   output soc_io_pkg::io_rsp_t o_rsp,
   input  logic                i_gpio_irq,
   input  logic                i_ram_init_done,
   input  logic                i_ram_init_error,
   output logic                o_sw_irq3,
   output logic                o_sw_irq4
);
   import soc_io_pkg::*;

   logic [1:0]            sw_irq;
   logic [`IO_DATA_W-1:0] rd_data;
   logic [`IO_DATA_W-1:0] rdata_q;
   logic                  hit;
   logic                  req_new;
   logic                  ack_q;
   logic                  err_q;

   always_comb begin
      hit     = 1'b1;
      rd_data = '0;
      case (i_req.addr[7:0])
         `SYSCON_ID:     rd_data = `SYSCON_ID_VALUE;
         `SYSCON_SW_IRQ: rd_data = {30'd0, sw_irq};
         `SYSCON_STATUS: rd_data = {29'd0, i_gpio_irq, i_ram_init_error, i_ram_init_done};
         default:        hit = 1'b0;
      endcase
   end

   assign req_new = i_req.stb && !ack_q && !err_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sw_irq <= 2'b00;
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         // Only byte 0 of SW_IRQ is writable
         if (req_new && (i_req.op == OP_WRITE) && i_req.strb[0] &&
             (i_req.addr[7:0] == `SYSCON_SW_IRQ))
            sw_irq <= i_req.wdata[1:0];
         ack_q <= req_new && hit;
         err_q <= req_new && !hit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (req_new)
         rdata_q <= (hit && (i_req.op == OP_READ)) ? rd_data : '0;
   end

   assign o_rsp     = '{ack: ack_q, err: err_q, rdata: rdata_q};
   assign o_sw_irq3 = sw_irq[0];
   assign o_sw_irq4 = sw_irq[1];

endmodule

//--- source/soc_io_top.sv
// I/O path top level
// AXI4-Lite bridge, region decoder, GPIO and system controller
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module soc_io_top (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic [`IO_ADDR_W-1:0] i_awaddr,
   input  logic                  i_awvalid,
   output logic                  o_awready,
   input  logic [`IO_DATA_W-1:0] i_wdata,
   input  logic [`IO_STRB_W-1:0] i_wstrb,
   input  logic                  i_wvalid,
   output logic                  o_wready,
   output logic [1:0]            o_bresp,
   output logic                  o_bvalid,
   input  logic                  i_bready,
   input  logic [`IO_ADDR_W-1:0] i_araddr,
   input  logic                  i_arvalid,
   output logic                  o_arready,
   output logic [`IO_DATA_W-1:0] o_rdata,
   output logic [1:0]            o_rresp,
   output logic                  o_rvalid,
   input  logic                  i_rready,
   input  logic [`IO_DATA_W-1:0] i_gpio,
   output soc_io_pkg::gpio_pad_t o_gpio,
   input  logic                  i_ram_init_done,
   input  logic                  i_ram_init_error,
   output logic                  o_gpio_irq,
   output logic                  o_sw_irq3,
   output logic                  o_sw_irq4
);
   import soc_io_pkg::*;

   io_req_t bus_req;
   io_rsp_t bus_rsp;
   io_req_t gpio_req;
   io_rsp_t gpio_rsp;
   io_req_t sys_req;
   io_rsp_t sys_rsp;

   axil_wb_bridge bridge_i (
      .i_clk, .i_rst_n,
      .i_awaddr, .i_awvalid, .o_awready,
      .i_wdata, .i_wstrb, .i_wvalid, .o_wready,
      .o_bresp, .o_bvalid, .i_bready,
      .i_araddr, .i_arvalid, .o_arready,
      .o_rdata, .o_rresp, .o_rvalid, .i_rready,
      .o_req (bus_req),
      .i_rsp (bus_rsp)
   );

   io_addr_decode decode_i (
      .i_clk, .i_rst_n,
      .i_req      (bus_req),
      .o_rsp      (bus_rsp),
      .o_gpio_req (gpio_req),
      .i_gpio_rsp (gpio_rsp),
      .o_sys_req  (sys_req),
      .i_sys_rsp  (sys_rsp)
   );

   gpio_regs gpio_i (
      .i_clk, .i_rst_n,
      .i_req  (gpio_req),
      .o_rsp  (gpio_rsp),
      .i_gpio (i_gpio),
      .o_pad  (o_gpio),
      .o_irq  (o_gpio_irq)
   );

   syscon_regs syscon_i (
      .i_clk, .i_rst_n,
      .i_req            (sys_req),
      .o_rsp            (sys_rsp),
      .i_gpio_irq       (o_gpio_irq),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_sw_irq3        (o_sw_irq3),
      .o_sw_irq4        (o_sw_irq4)
   );

endmodule

//--- verif/soc_io_props.sv
// Bound assertions on the bridge handshake and the internal bus
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module soc_io_props (
   input logic                  i_clk,
   input logic                  i_rst_n,
   input logic                  i_bvalid,
   input logic                  i_bready,
   input logic [1:0]            i_bresp,
   input logic                  i_rvalid,
   input logic                  i_rready,
   input logic [1:0]            i_rresp,
   input logic [`IO_DATA_W-1:0] i_rdata,
   input soc_io_pkg::io_req_t   i_req,
   input soc_io_pkg::io_rsp_t   i_rsp
);

   // Count of failed assertions
   int unsigned n_fail = 0;

   // B and R held with stable payload until accepted
   a_b_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
      else begin
         n_fail++;
         $error("write response dropped or changed before bready");
      end

   a_r_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rvalid && !i_rready |=> i_rvalid && $stable(i_rresp) && $stable(i_rdata))
      else begin
         n_fail++;
         $error("read response dropped or changed before rready");
      end

   a_stb_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_req.stb && !i_rsp.ack && !i_rsp.err |=> i_req.stb)
      else begin
         n_fail++;
         $error("stb dropped before ack or err");
      end

   a_ack_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_rsp.ack && i_rsp.err))
      else begin
         n_fail++;
         $error("ack and err high in the same cycle");
      end

   // Quiet response channels while in reset
   a_rst_quiet: assert property (@(posedge i_clk)
      !i_rst_n |-> !i_bvalid && !i_rvalid)
      else begin
         n_fail++;
         $error("response valid raised during reset");
      end

endmodule

//--- verif/soc_io_tb.sv
// Testbench for the I/O path top level
// Random AXI4-Lite traffic checked against a register model
`timescale 1ns/100ps
`include "soc_io_defs.svh"

module soc_io_tb;
   import soc_io_pkg::*;

   localparam int MAX_WAIT = 64;

   logic                  i_clk;
   logic                  i_rst_n;
   logic [`IO_ADDR_W-1:0] i_awaddr;
   logic                  i_awvalid;
   logic                  o_awready;
   logic [`IO_DATA_W-1:0] i_wdata;
   logic [`IO_STRB_W-1:0] i_wstrb;
   logic                  i_wvalid;
   logic                  o_wready;
   logic [1:0]            o_bresp;
   logic                  o_bvalid;
   logic                  i_bready;
   logic [`IO_ADDR_W-1:0] i_araddr;
   logic                  i_arvalid;
   logic                  o_arready;
   logic [`IO_DATA_W-1:0] o_rdata;
   logic [1:0]            o_rresp;
   logic                  o_rvalid;
   logic                  i_rready;
   logic [`IO_DATA_W-1:0] i_gpio;
   gpio_pad_t             o_gpio;
   logic                  i_ram_init_done;
   logic                  i_ram_init_error;
   logic                  o_gpio_irq;
   logic                  o_sw_irq3;
   logic                  o_sw_irq4;

   // Register model
   logic [31:0] m_out;
   logic [31:0] m_dir;
   logic [31:0] m_mask;
   logic [31:0] m_stat;
   logic [1:0]  m_sw;
   int unsigned n_checks;
   int unsigned n_err;
   int unsigned n_tmo;

   soc_io_top dut_i (.*);

   bind axil_wb_bridge soc_io_props props_i (
      .i_clk, .i_rst_n,
      .i_bvalid (o_bvalid),
      .i_bready (i_bready),
      .i_bresp  (o_bresp),
      .i_rvalid (o_rvalid),
      .i_rready (i_rready),
      .i_rresp  (o_rresp),
      .i_rdata  (o_rdata),
      .i_req    (o_req),
      .i_rsp    (i_rsp)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   //**************************************************************************
   // Checks and model
   //**************************************************************************

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_err++;
         $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   function automatic logic [31:0] byte_mask(input logic [3:0] strb);
      logic [31:0] m;
      for (int b = 0; b < 4; b++)
         m[b*8 +: 8] = {8{strb[b]}};
      return m;
   endfunction

   // Expected response code and read data, updates the model on writes
   task automatic model_access(input logic wr, input logic [15:0] addr,
                               input logic [31:0] data, input logic [3:0] strb,
                               output logic [1:0] resp, output logic [31:0] rd);
      logic [31:0] bm;
      bm   = byte_mask(strb);
      resp = `RESP_OKAY;
      rd   = '0;
      if ((addr & 16'hff00) == `GPIO_BASE) begin
         case (addr[7:0])
            `GPIO_DATA_IN:  rd = i_gpio;
            `GPIO_DATA_OUT: rd = m_out;
            `GPIO_DIR:      rd = m_dir;
            `GPIO_IRQ_MASK: rd = m_mask;
            `GPIO_IRQ_STAT: rd = m_stat;
            default:        resp = `RESP_SLVERR;
         endcase
         if (wr && (resp == `RESP_OKAY)) begin
            case (addr[7:0])
               `GPIO_DATA_OUT: m_out  = (m_out & ~bm) | (data & bm);
               `GPIO_DIR:      m_dir  = (m_dir & ~bm) | (data & bm);
               `GPIO_IRQ_MASK: m_mask = (m_mask & ~bm) | (data & bm);
               `GPIO_IRQ_STAT: m_stat = m_stat & ~(data & bm);
               default: ;
            endcase
         end
      end else if ((addr & 16'hff00) == `SYSCON_BASE) begin
         case (addr[7:0])
            `SYSCON_ID:     rd = `SYSCON_ID_VALUE;
            `SYSCON_SW_IRQ: rd = {30'd0, m_sw};
            `SYSCON_STATUS: rd = {29'd0, |(m_stat & m_mask), i_ram_init_error, i_ram_init_done};
            default:        resp = `RESP_SLVERR;
         endcase
         if (wr && strb[0] && (addr[7:0] == `SYSCON_SW_IRQ))
            m_sw = data[1:0];
      end else begin
         resp = `RESP_SLVERR;
      end
      if (wr || (resp != `RESP_OKAY))
         rd = '0;
   endtask

   //**************************************************************************
   // AXI4-Lite master
   //**************************************************************************

   // One access with random AW/W order and random ready stalls
   task automatic axi_access(input logic wr, input logic [15:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             output logic [1:0] resp, output logic [31:0] rd);
      int unsigned a_dly;
      int unsigned w_dly;
      int unsigned cyc;
      logic        a_left;
      logic        w_left;
      logic        a_fire;
      logic        w_fire;
      logic        seen;
      logic        done;
      a_dly  = 0;
      w_dly  = 0;
      resp   = 'x;
      rd     = 'x;
      if (wr && $urandom_range(0, 1))
         a_dly = $urandom_range(0, 4);
      else if (wr)
         w_dly = $urandom_range(0, 4);
      a_left = 1'b1;
      w_left = wr;
      a_fire = 1'b0;
      w_fire = 1'b0;
      cyc    = 0;
      while ((a_left || w_left) && (cyc < MAX_WAIT)) begin
         @(negedge i_clk);
         if (a_fire) begin
            i_awvalid = 1'b0;
            i_arvalid = 1'b0;
            a_left    = 1'b0;
         end
         if (w_fire) begin
            i_wvalid = 1'b0;
            w_left   = 1'b0;
         end
         if (a_left && (cyc >= a_dly) && wr) begin
            i_awaddr  = addr;
            i_awvalid = 1'b1;
         end else if (a_left && !wr) begin
            i_araddr  = addr;
            i_arvalid = 1'b1;
         end
         if (w_left && (cyc >= w_dly)) begin
            i_wdata  = data;
            i_wstrb  = strb;
            i_wvalid = 1'b1;
         end
         #1;
         a_fire = wr ? (i_awvalid && o_awready) : (i_arvalid && o_arready);
         w_fire = i_wvalid && o_wready;
         cyc++;
      end
      if (a_left || w_left) begin
         n_tmo++;
         $display("Timeout: address or data beat not accepted at %0t", $time);
         i_awvalid = 1'b0;
         i_arvalid = 1'b0;
         i_wvalid  = 1'b0;
      end
      seen = 1'b0;
      done = 1'b0;
      cyc  = 0;
      while (!done && (cyc < MAX_WAIT)) begin
         @(negedge i_clk);
         i_bready = ($urandom_range(0, 2) != 0);
         i_rready = ($urandom_range(0, 2) != 0);
         #1;
         if (seen) begin
            // Stalled response must not move
            check_val(wr ? "o_bvalid" : "o_rvalid", wr ? o_bvalid : o_rvalid, 1);
            check_val(wr ? "o_bresp" : "o_rresp", wr ? o_bresp : o_rresp, resp);
            if (!wr)
               check_val("o_rdata", o_rdata, rd);
         end else if (wr ? o_bvalid : o_rvalid) begin
            seen = 1'b1;
            resp = wr ? o_bresp : o_rresp;
            rd   = wr ? '0 : o_rdata;
         end
         done = seen && (wr ? i_bready : i_rready);
         cyc++;
      end
      if (!done) begin
         n_tmo++;
         $display("Timeout: response never accepted at %0t", $time);
      end
   endtask

   task automatic access_check(input logic wr, input logic [15:0] addr,
                               input logic [31:0] data, input logic [3:0] strb);
      logic [1:0]  exp_resp;
      logic [31:0] exp_rd;
      logic [1:0]  resp;
      logic [31:0] rd;
      model_access(wr, addr, data, strb, exp_resp, exp_rd);
      axi_access(wr, addr, data, strb, resp, rd);
      check_val(wr ? "o_bresp" : "o_rresp", resp, exp_resp);
      if (!wr)
         check_val("o_rdata", rd, exp_rd);
      check_val("o_gpio.out", o_gpio.out, m_out);
      check_val("o_gpio.oe", o_gpio.oe, m_dir);
      check_val("o_gpio_irq", o_gpio_irq, |(m_stat & m_mask));
      check_val("o_sw_irq3", o_sw_irq3, m_sw[0]);
      check_val("o_sw_irq4", o_sw_irq4, m_sw[1]);
   endtask

   // New pin value, then let it pass the synchroniser
   task automatic gpio_change();
      logic [31:0] nv;
      nv = i_gpio ^ ($urandom() & $urandom());
      @(negedge i_clk);
      m_stat = m_stat | (i_gpio ^ nv);
      i_gpio = nv;
      repeat (4) @(negedge i_clk);
      check_val("o_gpio_irq", o_gpio_irq, |(m_stat & m_mask));
   endtask

   //**************************************************************************
   // Test sequence
   //**************************************************************************

   initial begin
      logic [15:0] addr;
      void'($urandom(32'h5ec02d9b));
      i_rst_n          = 1'b0;
      i_awaddr         = '0;
      i_awvalid        = 1'b0;
      i_wdata          = '0;
      i_wstrb          = '0;
      i_wvalid         = 1'b0;
      i_bready         = 1'b0;
      i_araddr         = '0;
      i_arvalid        = 1'b0;
      i_rready         = 1'b0;
      i_gpio           = '0;
      i_ram_init_done  = 1'b0;
      i_ram_init_error = 1'b0;
      m_out            = '0;
      m_dir            = '0;
      m_mask           = '0;
      m_stat           = '0;
      m_sw             = '0;
      n_checks         = 0;
      n_err            = 0;
      n_tmo            = 0;
      repeat (10) @(negedge i_clk);
      i_rst_n = 1'b1;
      #1;
      check_val("o_bvalid", o_bvalid, 0);
      check_val("o_rvalid", o_rvalid, 0);
      check_val("o_awready", o_awready, 1);
      check_val("o_wready", o_wready, 1);
      check_val("o_arready", o_arready, 1);
      check_val("o_gpio.out", o_gpio.out, 0);
      check_val("o_gpio.oe", o_gpio.oe, 0);
      check_val("o_gpio_irq", o_gpio_irq, 0);
      check_val("o_sw_irq3", o_sw_irq3, 0);
      check_val("o_sw_irq4", o_sw_irq4, 0);

      // GPIO control registers, write and read back
      repeat (40) begin
         addr = {8'h00, 8'(4 * $urandom_range(1, 3))};
         access_check(1'b1, addr, $urandom(), 4'($urandom()));
         access_check(1'b0, addr, '0, '0);
      end

      // Pin changes, status and clearing
      access_check(1'b1, `GPIO_BASE + `GPIO_IRQ_MASK, $urandom(), 4'hf);
      repeat (20) begin
         gpio_change();
         access_check(1'b0, `GPIO_BASE + `GPIO_DATA_IN, '0, '0);
         access_check(1'b0, `GPIO_BASE + `GPIO_IRQ_STAT, '0, '0);
         if ($urandom_range(0, 2) == 0)
            access_check(1'b1, `GPIO_BASE + `GPIO_IRQ_STAT, $urandom(), 4'($urandom()));
      end

      // System controller, GPIO interrupt masked on and off
      access_check(1'b0, `SYSCON_BASE + `SYSCON_ID, '0, '0);
      repeat (12) begin
         access_check(1'b1, `GPIO_BASE + `GPIO_IRQ_MASK,
                      {32{1'($urandom_range(0, 1))}}, 4'hf);
         @(negedge i_clk);
         i_ram_init_done  = 1'($urandom_range(0, 1));
         i_ram_init_error = 1'($urandom_range(0, 1));
         access_check(1'b1, `SYSCON_BASE + `SYSCON_SW_IRQ, $urandom(), 4'($urandom()));
         access_check(1'b0, `SYSCON_BASE + `SYSCON_SW_IRQ, '0, '0);
         access_check(1'b0, `SYSCON_BASE + `SYSCON_STATUS, '0, '0);
      end

      // Unmapped regions and bad offsets mixed with legal ones
      repeat (40) begin
         addr = {8'($urandom_range(0, 3)), 8'($urandom_range(0, 31))};
         access_check(1'($urandom_range(0, 1)), addr, $urandom(), 4'($urandom()));
      end
      access_check(1'b0, `GPIO_BASE + `GPIO_DATA_OUT, '0, '0);
      access_check(1'b0, `GPIO_BASE + `GPIO_DIR, '0, '0);
      access_check(1'b0, `GPIO_BASE + `GPIO_IRQ_MASK, '0, '0);
      access_check(1'b0, `GPIO_BASE + `GPIO_IRQ_STAT, '0, '0);
      access_check(1'b0, `SYSCON_BASE + `SYSCON_SW_IRQ, '0, '0);

      $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
               n_checks, n_err, n_tmo, dut_i.bridge_i.props_i.n_fail);
      if ((n_err == 0) && (n_tmo == 0) && (dut_i.bridge_i.props_i.n_fail == 0))
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+source
source/soc_io_pkg.sv
source/axil_wb_bridge.sv
source/io_addr_decode.sv
source/gpio_regs.sv
source/syscon_regs.sv
source/soc_io_top.sv
verif/soc_io_props.sv
verif/soc_io_tb.sv

//--- Bender.yml
package:
  name: soc_io

sources:
  - include_dirs:
      - source
    files:
      - source/soc_io_pkg.sv
      - source/axil_wb_bridge.sv
      - source/io_addr_decode.sv
      - source/gpio_regs.sv
      - source/syscon_regs.sv
      - source/soc_io_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/soc_io_props.sv
      - verif/soc_io_tb.sv
